//--- cpu_params.svh
// sizing constants shared by the processor core and its stages
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data path width
`define CPU_XLEN 32

// instruction memory words; the pc width must address all of them
`define CPU_IMEM_DEPTH 256
`define CPU_PC_W 8

// general registers, register 0 reads as zero
`define CPU_NREGS 32

`endif

//--- isa_pkg.sv
// instruction set of the core: opcodes, field types and word layouts
package isa_pkg;

   typedef logic [4:0]  reg_idx_t;
   typedef logic [15:0] imm_t;

   typedef enum logic [5:0] {
      OP_NOP  = 6'h00,
      OP_ADD  = 6'h01,
      OP_SUB  = 6'h02,
      OP_AND  = 6'h03,
      OP_OR   = 6'h04,
      OP_SLT  = 6'h05,
      OP_ADDI = 6'h08,
      OP_BEQ  = 6'h10,
      OP_BNE  = 6'h11,
      OP_JMP  = 6'h12,
      OP_SEND = 6'h20,
      OP_HALT = 6'h3f
   } opcode_e;

   typedef struct packed {
      opcode_e     op;
      reg_idx_t    rs;
      reg_idx_t    rt;
      reg_idx_t    rd;
      logic [10:0] spare;   // not decoded
   } instr_r_t;

   typedef struct packed {
      opcode_e  op;
      reg_idx_t rs;
      reg_idx_t rt;
      imm_t     imm;
   } instr_i_t;

endpackage

//--- pipe_pkg.sv
// pipeline control encodings and the record carried from decode into execute
`include "cpu_params.svh"

package pipe_pkg;

   typedef enum logic [1:0] {LD_COUNT_HI, LD_COUNT_LO, LD_WORDS, LD_DONE} loader_state_e;

   typedef enum logic [1:0] {CORE_LOAD, CORE_RUN, CORE_HALT} core_state_e;

   typedef struct packed {
      isa_pkg::opcode_e     op;
      isa_pkg::reg_idx_t    dest;
      logic                 dest_valid;
      logic [`CPU_XLEN-1:0] rs_val;
      logic [`CPU_XLEN-1:0] rt_val;
      logic [`CPU_XLEN-1:0] imm;       // already sign extended
      logic [`CPU_PC_W-1:0] pc;
   } issue_t;

endpackage

//--- cpu_ifs.sv
// stage-to-stage bundles of the core: register read and instruction issue
`timescale 1ns/10ps
`include "cpu_params.svh"

interface reg_read_if;
   import isa_pkg::*;

   reg_idx_t             rs_idx;
   reg_idx_t             rt_idx;
   logic [`CPU_XLEN-1:0] rs_data;
   logic [`CPU_XLEN-1:0] rt_data;

   modport requester (output rs_idx, output rt_idx, input rs_data, input rt_data);
   modport responder (input rs_idx, input rt_idx, output rs_data, output rt_data);
endinterface

interface issue_if;
   import pipe_pkg::*;

   logic   valid;   // one cycle per issued instruction
   issue_t info;

   modport sender (output valid, output info);
   modport receiver (input valid, input info);
endinterface

//--- program_loader.sv
// program loader: builds instruction words from the received byte stream, then starts the core
`timescale 1ns/10ps
`include "cpu_params.svh"

module program_loader (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 rx_valid,
   input  logic [7:0]           rx_data,
   output logic                 imem_we,
   output logic [`CPU_PC_W-1:0] imem_waddr,
   output logic [`CPU_XLEN-1:0] imem_wdata,
   output logic                 start
);
   import pipe_pkg::*;

   loader_state_e        state;
   logic [15:0]          words_left;
   logic [1:0]           byte_idx;
   logic [`CPU_PC_W-1:0] next_addr;
   logic [23:0]          word_buf;
   logic                 take_byte;
   logic                 word_done;

   assign take_byte = rx_valid && (state == LD_WORDS);
   assign word_done = take_byte && (byte_idx == 2'd3);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= LD_COUNT_HI;
         words_left <= '0;
         byte_idx   <= '0;
         next_addr  <= '0;
         imem_we    <= 1'b0;
         start      <= 1'b0;
      end else begin
         imem_we <= word_done;
         start   <= 1'b0;
         case (state)
            LD_COUNT_HI: begin
               if (rx_valid) begin
                  words_left[15:8] <= rx_data;
                  state            <= LD_COUNT_LO;
               end
            end
            LD_COUNT_LO: begin
               if (rx_valid) begin
                  words_left[7:0] <= rx_data;
                  if ({words_left[15:8], rx_data} == 16'd0) begin
                     state <= LD_DONE;   // empty program runs whatever memory holds
                     start <= 1'b1;
                  end else begin
                     state <= LD_WORDS;
                  end
               end
            end
            LD_WORDS: begin
               if (take_byte) begin
                  byte_idx <= byte_idx + 1'b1;   // wraps to 0 after the fourth byte
               end
               if (word_done) begin
                  next_addr  <= next_addr + 1'b1;
                  words_left <= words_left - 1'b1;
                  if (words_left == 16'd1) begin
                     state <= LD_DONE;
                  end
               end
            end
            default: start <= imem_we;   // fires once, right after the final write
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take_byte) begin
         word_buf <= {word_buf[15:0], rx_data};
      end
      if (word_done) begin
         imem_wdata <= {word_buf, rx_data};   // most significant byte came first
         imem_waddr <= next_addr;
      end
   end

endmodule

//--- decode_stage.sv
// decode stage: instruction memory, pc, core state, hazard scoreboard and issue register
`timescale 1ns/10ps
`include "cpu_params.svh"

module decode_stage (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 imem_we,
   input  logic [`CPU_PC_W-1:0] imem_waddr,
   input  logic [`CPU_XLEN-1:0] imem_wdata,
   input  logic                 start,
   input  logic                 redirect_valid,
   input  logic [`CPU_PC_W-1:0] redirect_pc,
   input  logic                 halt_seen,
   reg_read_if.requester        rd,
   issue_if.sender              iss,
   output logic                 running,
   output logic                 halted
);
   import isa_pkg::*;
   import pipe_pkg::*;

   logic [`CPU_XLEN-1:0] imem [`CPU_IMEM_DEPTH];
   core_state_e          core_state;
   logic [`CPU_PC_W-1:0] pc;
   logic [`CPU_PC_W-1:0] fetch_pc;
   logic [`CPU_XLEN-1:0] fetch_word;
   logic                 fetch_valid;
   instr_r_t             ir;
   instr_i_t             ii;
   logic                 has_dest;
   reg_idx_t             dest;
   logic [1:0]           sb_valid;
   reg_idx_t             sb_dest [2];
   logic                 rs_busy;
   logic                 rt_busy;
   logic                 stall;
   logic                 issue_go;

   assign ir        = instr_r_t'(fetch_word);
   assign ii        = instr_i_t'(fetch_word);
   assign rd.rs_idx = ii.rs;
   assign rd.rt_idx = ii.rt;
   assign running   = (core_state == CORE_RUN);
   assign halted    = (core_state == CORE_HALT);

   // entry 0 mirrors the issue register, entry 1 the execute register
   assign rs_busy = (ii.rs != '0) && ((sb_valid[0] && sb_dest[0] == ii.rs) ||
                                      (sb_valid[1] && sb_dest[1] == ii.rs));
   assign rt_busy = (ii.rt != '0) && ((sb_valid[0] && sb_dest[0] == ii.rt) ||
                                      (sb_valid[1] && sb_dest[1] == ii.rt));
   assign stall    = fetch_valid && (rs_busy || rt_busy);
   assign issue_go = fetch_valid && !stall && !redirect_valid && !halt_seen;

   always_comb begin
      has_dest = 1'b0;
      dest     = ir.rd;
      case (ii.op)
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT: has_dest = 1'b1;
         OP_ADDI: begin
            has_dest = 1'b1;
            dest     = ii.rt;
         end
         default: has_dest = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         core_state  <= CORE_LOAD;
         pc          <= '0;
         fetch_valid <= 1'b0;
         sb_valid    <= '0;
         iss.valid   <= 1'b0;
      end else begin
         iss.valid <= issue_go;   // a stall or flush leaves a bubble
         sb_valid  <= {sb_valid[0], issue_go && has_dest};
         case (core_state)
            CORE_LOAD: begin
               if (start) begin
                  core_state <= CORE_RUN;
               end
            end
            CORE_RUN: begin
               if (halt_seen) begin
                  core_state  <= CORE_HALT;
                  fetch_valid <= 1'b0;
               end else if (redirect_valid) begin
                  pc          <= redirect_pc;
                  fetch_valid <= 1'b0;   // drop the word already fetched
               end else if (!stall) begin
                  pc          <= pc + 1'b1;
                  fetch_valid <= 1'b1;
               end
            end
            default: fetch_valid <= 1'b0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (imem_we) begin
         imem[imem_waddr] <= imem_wdata;
      end
      if (!stall) begin
         fetch_word <= imem[pc];
         fetch_pc   <= pc;
      end
      sb_dest[0]          <= dest;
      sb_dest[1]          <= sb_dest[0];
      iss.info.op         <= ii.op;
      iss.info.dest       <= dest;
      iss.info.dest_valid <= has_dest;
      iss.info.rs_val     <= rd.rs_data;
      iss.info.rt_val     <= rd.rt_data;
      iss.info.imm        <= {{(`CPU_XLEN-16){ii.imm[15]}}, ii.imm};
      iss.info.pc         <= fetch_pc;
   end

endmodule

//--- execute_stage.sv
// execute stage: ALU, branch resolution, transmit strobe and halt detection
`timescale 1ns/10ps
`include "cpu_params.svh"

module execute_stage (
   input  logic                 clk,
   input  logic                 rst_n,
   issue_if.receiver            iss,
   output logic                 redirect_valid,
   output logic [`CPU_PC_W-1:0] redirect_pc,
   output logic                 halt_seen,
   output logic                 tx_valid,
   output logic [7:0]           tx_data,
   output logic                 wb_valid,
   output isa_pkg::reg_idx_t    wb_dest,
   output logic [`CPU_XLEN-1:0] wb_data
);
   import isa_pkg::*;

   logic                 live;
   logic [`CPU_XLEN-1:0] a;
   logic [`CPU_XLEN-1:0] b;
   logic [`CPU_XLEN-1:0] alu_out;
   logic                 taken;
   logic [`CPU_PC_W-1:0] target;

   assign a = iss.info.rs_val;
   assign b = iss.info.rt_val;

   // the slot behind a taken branch is already fetched, and nothing runs after halt
   assign live = iss.valid && !redirect_valid && !halt_seen;

   always_comb begin
      alu_out = '0;
      taken   = 1'b0;
      target  = iss.info.pc + 1'b1 + iss.info.imm[`CPU_PC_W-1:0];
      case (iss.info.op)
         OP_ADD:  alu_out = a + b;
         OP_SUB:  alu_out = a - b;
         OP_AND:  alu_out = a & b;
         OP_OR:   alu_out = a | b;
         OP_SLT:  alu_out = {{(`CPU_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
         OP_ADDI: alu_out = a + iss.info.imm;
         OP_BEQ:  taken = (a == b);
         OP_BNE:  taken = (a != b);
         OP_JMP: begin
            taken  = 1'b1;
            target = iss.info.imm[`CPU_PC_W-1:0];   // absolute word address
         end
         default: alu_out = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         redirect_valid <= 1'b0;
         halt_seen      <= 1'b0;
         tx_valid       <= 1'b0;
         wb_valid       <= 1'b0;
      end else begin
         redirect_valid <= live && taken;
         halt_seen      <= halt_seen || (live && iss.info.op == OP_HALT);   // sticky
         tx_valid       <= live && (iss.info.op == OP_SEND);
         wb_valid       <= live && iss.info.dest_valid;
      end
   end

   always_ff @(posedge clk) begin
      redirect_pc <= target;
      tx_data     <= b[7:0];
      wb_dest     <= iss.info.dest;
      wb_data     <= alu_out;
   end

endmodule

//--- result_stage.sv
// result stage: general register file with two read ports and the write-back port
`timescale 1ns/10ps
`include "cpu_params.svh"

module result_stage (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 wb_valid,
   input  isa_pkg::reg_idx_t    wb_dest,
   input  logic [`CPU_XLEN-1:0] wb_data,
   reg_read_if.responder        rd
);

   logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `CPU_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_valid && wb_dest != '0) begin
         regs[wb_dest] <= wb_data;   // register 0 is hardwired
      end
   end

   // reads are combinational, so a write shows up on the next cycle
   assign rd.rs_data = (rd.rs_idx == '0) ? '0 : regs[rd.rs_idx];
   assign rd.rt_data = (rd.rt_idx == '0) ? '0 : regs[rd.rt_idx];

endmodule

//--- cpu_top.sv
// processor top: byte-stream program loader feeding the decode, execute and result stages
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpu_top (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       rx_valid,
   input  logic [7:0] rx_data,
   output logic       tx_valid,
   output logic [7:0] tx_data,
   output logic       running,
   output logic       halted
);
   import isa_pkg::*;

   logic                 imem_we;
   logic [`CPU_PC_W-1:0] imem_waddr;
   logic [`CPU_XLEN-1:0] imem_wdata;
   logic                 start;
   logic                 redirect_valid;
   logic [`CPU_PC_W-1:0] redirect_pc;
   logic                 halt_seen;
   logic                 wb_valid;
   reg_idx_t             wb_dest;
   logic [`CPU_XLEN-1:0] wb_data;

   reg_read_if rd_bus ();
   issue_if    iss_bus ();

   program_loader loader_inst (.clk(clk), .rst_n(rst_n),
                               .rx_valid(rx_valid), .rx_data(rx_data),
                               .imem_we(imem_we), .imem_waddr(imem_waddr),
                               .imem_wdata(imem_wdata), .start(start));

   decode_stage decode_inst (.clk(clk), .rst_n(rst_n),
                             .imem_we(imem_we), .imem_waddr(imem_waddr),
                             .imem_wdata(imem_wdata), .start(start),
                             .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
                             .halt_seen(halt_seen), .rd(rd_bus.requester),
                             .iss(iss_bus.sender), .running(running), .halted(halted));

   execute_stage execute_inst (.clk(clk), .rst_n(rst_n), .iss(iss_bus.receiver),
                               .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
                               .halt_seen(halt_seen), .tx_valid(tx_valid), .tx_data(tx_data),
                               .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data));

   result_stage result_inst (.clk(clk), .rst_n(rst_n), .wb_valid(wb_valid),
                             .wb_dest(wb_dest), .wb_data(wb_data), .rd(rd_bus.responder));

endmodule

//--- cpu_assertions.sv
// protocol checks on the processor top for the transmit strobe and the run and halt flags
`timescale 1ns/10ps

module cpu_assertions (
   input logic clk,
   input logic rst_n,
   input logic tx_valid,
   input logic running,
   input logic halted
);

   int failures = 0;

   tx_needs_run: assert property (@(posedge clk) disable iff (!rst_n) tx_valid |-> running)
      else begin
         failures++;
         $error("tx_valid is high while the core is not running");
      end

   run_halt_excl: assert property (@(posedge clk) disable iff (!rst_n) !(halted && running))
      else begin
         failures++;
         $error("halted and running are high together");
      end

   halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
      else begin
         failures++;
         $error("halted dropped without a reset");
      end

endmodule

bind cpu_top cpu_assertions protocol_checks (.clk(clk), .rst_n(rst_n), .tx_valid(tx_valid),
                                             .running(running), .halted(halted));

//--- tb_cpu.sv
// testbench for the processor core that streams programs from a data file and checks the tx bytes
`timescale 1ns/10ps

module tb_cpu;

   localparam int NAME_W = 8*16;

   logic              clk;
   logic              rst_n;
   logic              rx_valid;
   logic [7:0]        rx_data;
   logic              tx_valid;
   logic [7:0]        tx_data;
   logic              running;
   logic              halted;

   logic [NAME_W-1:0] test_name [$];
   int                word_first [$];
   int                word_count [$];
   int                byte_first [$];
   int                byte_count [$];
   logic [31:0]       prog_words [$];
   logic [7:0]        exp_bytes [$];
   logic [7:0]        tx_seen [$];
   logic [31:0]       lfsr;
   int                total_words = 0;
   int                errors = 0;
   bit                loaded = 1'b0;
   bit                saw_running = 1'b0;

   cpu_top DUT (.clk(clk), .rst_n(rst_n), .rx_valid(rx_valid), .rx_data(rx_data),
                .tx_valid(tx_valid), .tx_data(tx_data), .running(running), .halted(halted));

   initial clk = 1'b0;
   always #2 clk = ~clk;

   always @(negedge clk) begin
      if (rst_n && tx_valid) begin
         tx_seen.push_back(tx_data);
      end
      if (rst_n && running === 1'b1) begin
         saw_running = 1'b1;
      end
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h80200003;   // taps for x^32 + x^22 + x^2 + x + 1
      end
      return n;
   endfunction

   function automatic int random_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         v = (v << 1) | lfsr[0];
         lfsr = lfsr_next(lfsr);
      end
      return v;
   endfunction

   task automatic read_tests(output bit ok);
      int                fd;
      int                n;
      int                code;
      logic [NAME_W-1:0] tok;
      logic [8*100-1:0]  rest;
      logic [31:0]       w;
      logic [7:0]        b;
      fd = $fopen("cpu_tests.txt", "r");
      ok = (fd != 0);
      if (ok) begin
         while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
               code = $fgets(rest, fd);   // rest of a comment line
            end else begin
               test_name.push_back(tok);
               code = $fscanf(fd, "%d", n);
               word_first.push_back(prog_words.size());
               word_count.push_back(n);
               total_words += n;
               for (int i = 0; i < n; i++) begin
                  code = $fscanf(fd, "%h", w);
                  prog_words.push_back(w);
               end
               code = $fscanf(fd, "%d", n);
               byte_first.push_back(exp_bytes.size());
               byte_count.push_back(n);
               for (int i = 0; i < n; i++) begin
                  code = $fscanf(fd, "%h", b);
                  exp_bytes.push_back(b);
               end
            end
         end
         $fclose(fd);
         ok = (test_name.size() > 0);
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #0.5;
      rst_n    = 1'b0;
      rx_valid = 1'b0;
      rx_data  = 8'h00;
      repeat (10) @(posedge clk);
      #0.5;
      rst_n = 1'b1;
   endtask

   task automatic send_byte(input logic [7:0] b);
      int gap;
      gap = random_bits(2);   // zero to three idle cycles ahead of the byte
      repeat (gap) begin
         @(posedge clk);
         #0.5;
         rx_valid = 1'b0;
      end
      @(posedge clk);
      #0.5;
      rx_valid = 1'b1;
      rx_data  = b;
   endtask

   task automatic run_test(input int t);
      logic [15:0] cnt;
      logic [31:0] w;
      int          nb;
      apply_reset();
      tx_seen.delete();
      saw_running = 1'b0;
      cnt = word_count[t];
      send_byte(cnt[15:8]);
      send_byte(cnt[7:0]);
      for (int i = 0; i < word_count[t]; i++) begin
         w = prog_words[word_first[t] + i];
         send_byte(w[31:24]);
         send_byte(w[23:16]);
         send_byte(w[15:8]);
         send_byte(w[7:0]);
      end
      @(posedge clk);
      #0.5;
      rx_valid = 1'b0;
      while (halted !== 1'b1) @(negedge clk);
      repeat (20) @(negedge clk);   // anything sent after the halt would land here
      assert (saw_running) else begin
         errors++;
         $display("ERR %0s: the core halted without ever entering run mode", test_name[t]);
      end
      assert (halted === 1'b1) else begin
         errors++;
         $display("ERR %0s: halted went low again before the next reset", test_name[t]);
      end
      nb = byte_count[t];
      assert (tx_seen.size() == nb) else begin
         errors++;
         $display("ERR %0s: expected %0d tx bytes, but the core sent %0d",
                  test_name[t], nb, tx_seen.size());
      end
      for (int i = 0; i < nb && i < tx_seen.size(); i++) begin
         assert (tx_seen[i] == exp_bytes[byte_first[t] + i]) else begin
            errors++;
            $display("ERR %0s: byte %0d expected %02h actual %02h",
                     test_name[t], i, exp_bytes[byte_first[t] + i], tx_seen[i]);
         end
      end
   endtask

   initial begin
      bit ok;
      rst_n    = 1'b0;
      rx_valid = 1'b0;
      rx_data  = 8'h00;
      lfsr     = 32'h5048bbc4;
      read_tests(ok);
      if (!ok) begin
         $display("could not read any test from cpu_tests.txt");
         $display("TEST FAIL");
         $finish;
      end else begin
         loaded = 1'b1;
         for (int t = 0; t < test_name.size(); t++) begin
            run_test(t);
         end
         $display("%0d tests, %0d check errors, %0d assertion failures",
                  test_name.size(), errors, DUT.protocol_checks.failures);
         if (errors == 0 && DUT.protocol_checks.failures == 0) begin
            $display("TEST PASS");
         end else begin
            $display("TEST FAIL");
         end
         $finish;
      end
   end

   // budget of 200 cycles for every program word over all tests
   initial begin
      wait (loaded);
      repeat (200 * total_words) @(posedge clk);
      $display("timeout: the tests did not finish within %0d cycles", 200 * total_words);
      $display("TEST FAIL");
      $finish;
   end

endmodule

//--- build.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
cpu_ifs.sv
program_loader.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
cpu_top.sv
cpu_assertions.sv
tb_cpu.sv

//--- cpu_tests.txt
# name word_count program_words(hex), then expected_tx_count expected_tx_bytes(hex)
# a record may run over several lines, a comment line only stands between records
arith 17
   20010005 2002FFFD 04221800 80030000 08222000 80040000
   0C222800 80050000 10223000 80060000 14413800 80070000
   14224000 80080000 20490010 80090000 FC000000
   7 02 08 05 FD 01 00 0D
chain 8
   20010001 04210800 04210800 20210003 80010000 04211000 80020000 FC000000
   2 07 0E
branch 12
   20020003 20210001 80010000 4422FFFD 40220001 80020000
   40200001 80020000 4800000A 80010000 44210005 FC000000
   4 01 02 03 03
reg_zero 5
   20000007 80000000 20010009 80010000 FC000000
   2 00 09
halt 5
   20010041 80010000 FC000000 80010000 80010000
   1 41
# leaves a halt at address 0 for the empty program that follows
halt_only 1
   FC000000
   0
empty 0
   0
